// File: files.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_router.sv
verilog/sram_bank.sv
verilog/soc_ctrl_regs.sv
verilog/gpio_port.sv
verilog/cmp_timer.sv
verilog/soc_domain.sv
test/tb_clock.sv
test/tb_soc_domain.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_soc_domain \
  -f files.f \
  -Mdir obj_dir

./obj_dir/Vtb_soc_domain | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Testbench reported a failure, see sim.log"
  exit 1
fi

echo "Run finished without failures"

// File: test/tb_soc_domain.sv
`timescale 1ns/100ps

`include "soc_macros.svh"

module tb_soc_domain;

  localparam int unsigned RspTimeout = 20;
  localparam int unsigned IrqTimeout = 100;
  localparam int unsigned ModelWords = 8;

  logic           clk;
  logic           rst_n;
  logic           fetch_en;
  logic           req;
  logic           we;
  soc_pkg::addr_t addr;
  soc_pkg::be_t   be;
  soc_pkg::word_t wdata;
  logic           gnt;
  logic           rvalid;
  soc_pkg::word_t rdata;
  logic           err;
  soc_pkg::gpio_t gpio_in;
  soc_pkg::gpio_t gpio_out;
  soc_pkg::gpio_t gpio_oe;
  soc_pkg::gpio_t gpio_sync;
  soc_pkg::addr_t boot_addr;
  logic           fetch_enable;
  logic           gpio_irq;
  logic           timer_irq;

  logic [31:0]    rng_state;
  int unsigned    test_errors;
  int unsigned    tests_passed;
  int unsigned    tests_failed;

  // Expected contents of a few words in each bank
  soc_pkg::word_t bank_model [2][ModelWords];

  tb_clock #(
    .PeriodNs ( 100 )
  ) i_tb_clock (
    .clk_o ( clk )
  );

  soc_domain soc_domain_i (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .fetch_en_i     ( fetch_en     ),
    .req_i          ( req          ),
    .we_i           ( we           ),
    .addr_i         ( addr         ),
    .be_i           ( be           ),
    .wdata_i        ( wdata        ),
    .gnt_o          ( gnt          ),
    .rvalid_o       ( rvalid       ),
    .rdata_o        ( rdata        ),
    .err_o          ( err          ),
    .gpio_i         ( gpio_in      ),
    .gpio_o         ( gpio_out     ),
    .gpio_out_en_o  ( gpio_oe      ),
    .gpio_in_sync_o ( gpio_sync    ),
    .boot_addr_o    ( boot_addr    ),
    .fetch_enable_o ( fetch_enable ),
    .gpio_irq_o     ( gpio_irq     ),
    .timer_irq_o    ( timer_irq    )
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Byte lanes with their enable set take the new data
  function automatic soc_pkg::word_t merge_bytes(soc_pkg::word_t old_word,
                                                 soc_pkg::word_t new_word,
                                                 soc_pkg::be_t enables);
    soc_pkg::word_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (enables[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  // Slots spread over the bank window
  function automatic soc_pkg::addr_t model_addr(int unsigned bank, int unsigned slot);
    soc_pkg::addr_t base;
    base = (bank == 0) ? `SOC_BANK0_BASE : `SOC_BANK1_BASE;
    return base + soc_pkg::addr_t'(slot * 132);
  endfunction

  task automatic check_word(string name, soc_pkg::word_t got, soc_pkg::word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_gpio(string name, soc_pkg::gpio_t got, soc_pkg::gpio_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic abort_run(string reason);
    $display("Run stopped: %s", reason);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic report_test(string name);
    if (test_errors == 0) begin
      $display("PASS  %s", name);
      tests_passed++;
    end else begin
      $display("FAIL  %s (%0d errors)", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic step_to_drive();
    @(posedge clk);
    #1;
  endtask

  // ----------------------------------------
  // Bus access
  // ----------------------------------------
  task automatic bus_access(input logic write, input soc_pkg::addr_t address,
                            input soc_pkg::be_t enables, input soc_pkg::word_t data,
                            output soc_pkg::word_t rsp_data, output logic rsp_err);
    int unsigned waited;
    step_to_drive();
    req   = 1'b1;
    we    = write;
    addr  = address;
    be    = enables;
    wdata = data;
    waited = 0;
    @(negedge clk);
    while (!gnt) begin
      waited++;
      if (waited > RspTimeout) begin
        abort_run("request was never granted");
      end
      @(negedge clk);
    end
    // Accepted at this edge
    step_to_drive();
    req = 1'b0;
    we  = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!rvalid) begin
      waited++;
      if (waited > RspTimeout) begin
        abort_run("no response after a granted request");
      end
      @(negedge clk);
    end
    rsp_data = rdata;
    rsp_err  = err;
  endtask

  task automatic bus_write(input soc_pkg::addr_t address, input soc_pkg::be_t enables,
                           input soc_pkg::word_t data, output logic rsp_err);
    soc_pkg::word_t unused;
    bus_access(1'b1, address, enables, data, unused, rsp_err);
  endtask

  task automatic bus_read(input soc_pkg::addr_t address, output soc_pkg::word_t data,
                          output logic rsp_err);
    bus_access(1'b0, address, 4'hF, '0, data, rsp_err);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_sram();
    soc_pkg::word_t data;
    soc_pkg::word_t got;
    soc_pkg::be_t   enables;
    logic           rsp_err;
    for (int bank = 0; bank < 2; bank++) begin
      for (int slot = 0; slot < ModelWords; slot++) begin
        data = next_random();
        bus_write(model_addr(bank, slot), 4'hF, data, rsp_err);
        bank_model[bank][slot] = data;
        check_bit("err_o", rsp_err, 1'b0);
      end
    end
    // Partial writes, a different lane pattern per slot
    for (int bank = 0; bank < 2; bank++) begin
      for (int slot = 0; slot < ModelWords; slot++) begin
        data    = next_random();
        enables = soc_pkg::be_t'(slot + 1 + bank * 7);
        bus_write(model_addr(bank, slot), enables, data, rsp_err);
        bank_model[bank][slot] = merge_bytes(bank_model[bank][slot], data, enables);
        check_bit("err_o", rsp_err, 1'b0);
      end
    end
    for (int bank = 0; bank < 2; bank++) begin
      for (int slot = 0; slot < ModelWords; slot++) begin
        bus_read(model_addr(bank, slot), got, rsp_err);
        check_word($sformatf("rdata_o bank%0d slot%0d", bank, slot), got,
                   bank_model[bank][slot]);
        check_bit("err_o", rsp_err, 1'b0);
      end
    end
    report_test("sram");
  endtask

  task automatic test_unmapped();
    soc_pkg::addr_t holes [5] = '{32'h0000_0000, 32'h1000_0800, 32'h0300_3000,
                                  32'h2000_0000, 32'hFFFF_FFFC};
    soc_pkg::word_t got;
    logic           rsp_err;
    for (int i = 0; i < 5; i++) begin
      bus_read(holes[i], got, rsp_err);
      check_word("rdata_o", got, `SOC_ERR_RDATA);
      check_bit("err_o", rsp_err, 1'b1);
      bus_write(holes[i], 4'hF, next_random(), rsp_err);
      check_bit("err_o", rsp_err, 1'b1);
    end
    report_test("unmapped space");
  endtask

  task automatic test_soc_ctrl();
    soc_pkg::word_t got;
    logic           rsp_err;
    check_word("boot_addr_o", boot_addr, `SOC_BOOT_ADDR);
    check_bit("fetch_enable_o", fetch_enable, 1'b0);
    bus_write(`SOC_CTRL_BASE, 4'hF, 32'h1000_0400, rsp_err);
    check_word("boot_addr_o", boot_addr, 32'h1000_0400);
    bus_read(`SOC_CTRL_BASE, got, rsp_err);
    check_word("rdata_o", got, 32'h1000_0400);
    // Pin alone
    step_to_drive();
    fetch_en = 1'b1;
    @(negedge clk);
    check_bit("fetch_enable_o", fetch_enable, 1'b1);
    step_to_drive();
    fetch_en = 1'b0;
    @(negedge clk);
    check_bit("fetch_enable_o", fetch_enable, 1'b0);
    // Register alone, then both
    bus_write(`SOC_CTRL_BASE + 32'h4, 4'hF, 32'h1, rsp_err);
    check_bit("fetch_enable_o", fetch_enable, 1'b1);
    step_to_drive();
    fetch_en = 1'b1;
    bus_write(`SOC_CTRL_BASE + 32'h4, 4'hF, 32'h0, rsp_err);
    check_bit("fetch_enable_o", fetch_enable, 1'b1);
    step_to_drive();
    fetch_en = 1'b0;
    @(negedge clk);
    check_bit("fetch_enable_o", fetch_enable, 1'b0);
    report_test("soc control");
  endtask

  task automatic test_gpio();
    soc_pkg::word_t got;
    logic           rsp_err;
    int unsigned    waited;
    bus_write(`SOC_GPIO_BASE, 4'hF, 32'h0000_A5F0, rsp_err);
    bus_write(`SOC_GPIO_BASE + 32'h4, 4'hF, 32'h0000_1234, rsp_err);
    check_gpio("gpio_out_en_o", gpio_oe, 16'hA5F0);
    check_gpio("gpio_o", gpio_out, 16'h1234);
    bus_read(`SOC_GPIO_BASE, got, rsp_err);
    check_word("rdata_o", got, 32'h0000_A5F0);
    // Synchronizer needs two edges
    step_to_drive();
    gpio_in = 16'h5A3C;
    @(posedge clk);
    @(negedge clk);
    check_gpio("gpio_in_sync_o", gpio_sync, 16'h0000);
    @(posedge clk);
    @(negedge clk);
    check_gpio("gpio_in_sync_o", gpio_sync, 16'h5A3C);
    bus_read(`SOC_GPIO_BASE + 32'h8, got, rsp_err);
    check_word("rdata_o", got, 32'h0000_5A3C);
    // Rising edge on pin 0
    bus_write(`SOC_GPIO_BASE + 32'hC, 4'hF, 32'h1, rsp_err);
    check_bit("gpio_irq_o", gpio_irq, 1'b0);
    step_to_drive();
    gpio_in = 16'h5A3D;
    waited = 0;
    @(negedge clk);
    while (!gpio_irq) begin
      waited++;
      if (waited > RspTimeout) begin
        abort_run("GPIO interrupt never rose after an enabled edge");
      end
      @(negedge clk);
    end
    bus_read(`SOC_GPIO_BASE + 32'h10, got, rsp_err);
    check_word("rdata_o", got, 32'h0000_0001);
    bus_write(`SOC_GPIO_BASE + 32'h10, 4'hF, 32'h1, rsp_err);
    check_bit("gpio_irq_o", gpio_irq, 1'b0);
    report_test("gpio");
  endtask

  task automatic test_timer();
    soc_pkg::word_t got;
    logic           rsp_err;
    logic           seen;
    int unsigned    waited;
    // Disabled and sitting on the compare value
    bus_write(`SOC_TIMER_BASE, 4'hF, 32'd20, rsp_err);
    bus_write(`SOC_TIMER_BASE + 32'h4, 4'hF, 32'd20, rsp_err);
    seen = 1'b0;
    repeat (30) begin
      @(negedge clk);
      seen = seen | timer_irq;
    end
    check_bit("timer_irq_o", seen, 1'b0);
    bus_write(`SOC_TIMER_BASE, 4'hF, 32'd0, rsp_err);
    bus_write(`SOC_TIMER_BASE + 32'h8, 4'hF, 32'h1, rsp_err);
    waited = 0;
    @(negedge clk);
    while (!timer_irq) begin
      waited++;
      if (waited > IrqTimeout) begin
        abort_run("timer interrupt never rose after enable");
      end
      @(negedge clk);
    end
    // Count runs from 0 to 20 first
    check_bit("timer_irq_o", waited < 20, 1'b0);
    bus_write(`SOC_TIMER_BASE + 32'h8, 4'hF, 32'h0, rsp_err);
    seen = 1'b1;
    repeat (30) begin
      @(negedge clk);
      seen = seen & timer_irq;
    end
    check_bit("timer_irq_o", seen, 1'b1);
    bus_read(`SOC_TIMER_BASE + 32'hC, got, rsp_err);
    check_word("rdata_o", got, 32'h0000_0001);
    bus_write(`SOC_TIMER_BASE + 32'hC, 4'hF, 32'h1, rsp_err);
    check_bit("timer_irq_o", timer_irq, 1'b0);
    seen = 1'b0;
    repeat (20) begin
      @(negedge clk);
      seen = seen | timer_irq;
    end
    check_bit("timer_irq_o", seen, 1'b0);
    report_test("timer");
  endtask

  task automatic test_pipeline();
    soc_pkg::word_t expected [ModelWords];
    for (int k = 0; k <= ModelWords; k++) begin
      step_to_drive();
      if (k < ModelWords) begin
        req  = 1'b1;
        we   = 1'b0;
        be   = 4'hF;
        addr = model_addr(k % 2, k);
        expected[k] = bank_model[k % 2][k];
      end else begin
        req = 1'b0;
      end
      @(negedge clk);
      if (k < ModelWords) begin
        check_bit("gnt_o", gnt, 1'b1);
      end
      // Response of the previous request
      if (k > 0) begin
        check_bit("rvalid_o", rvalid, 1'b1);
        check_word($sformatf("rdata_o read %0d", k - 1), rdata, expected[k - 1]);
        check_bit("err_o", err, 1'b0);
      end
    end
    @(negedge clk);
    check_bit("rvalid_o", rvalid, 1'b0);
    report_test("pipelining");
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rng_state    = 32'h5b2a2e33;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst_n    = 1'b0;
    fetch_en = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    be       = '0;
    wdata    = '0;
    gpio_in  = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("rvalid_o", rvalid, 1'b0);
    check_bit("err_o", err, 1'b0);
    check_gpio("gpio_out_en_o", gpio_oe, '0);
    check_gpio("gpio_o", gpio_out, '0);
    check_bit("gpio_irq_o", gpio_irq, 1'b0);
    check_bit("timer_irq_o", timer_irq, 1'b0);
    report_test("reset values");
    test_sram();
    test_unmapped();
    test_soc_ctrl();
    test_gpio();
    test_timer();
    test_pipeline();
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int unsigned PeriodNs = 100
) (
  output logic clk_o
);

  // Free-running, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

endmodule

// File: verilog/soc_domain.sv
`timescale 1ns/100ps

`include "soc_macros.svh"

module soc_domain (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            fetch_en_i,

  // Manager port
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::be_t    be_i,
  input  soc_pkg::word_t  wdata_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output soc_pkg::word_t  rdata_o,
  output logic            err_o,

  // GPIO pins
  input  soc_pkg::gpio_t  gpio_i,
  output soc_pkg::gpio_t  gpio_o,
  output soc_pkg::gpio_t  gpio_out_en_o,
  output soc_pkg::gpio_t  gpio_in_sync_o,

  // Control and interrupts
  output soc_pkg::addr_t  boot_addr_o,
  output logic            fetch_enable_o,
  output logic            gpio_irq_o,
  output logic            timer_irq_o
);

  // ----------------------------------------
  // Request fan-out from the router
  // ----------------------------------------
  logic           sel_bank0;
  logic           sel_bank1;
  logic           sel_ctrl;
  logic           sel_gpio;
  logic           sel_timer;
  logic           bus_we;
  soc_pkg::addr_t bus_addr;
  soc_pkg::be_t   bus_be;
  soc_pkg::word_t bus_wdata;

  // Read data back from each target
  soc_pkg::word_t rdata_bank0;
  soc_pkg::word_t rdata_bank1;
  soc_pkg::word_t rdata_ctrl;
  soc_pkg::word_t rdata_gpio;
  soc_pkg::word_t rdata_timer;

  bus_router i_bus_router (
    .clk_i,
    .rst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .err_o,
    .sel_bank0_o   ( sel_bank0   ),
    .sel_bank1_o   ( sel_bank1   ),
    .sel_ctrl_o    ( sel_ctrl    ),
    .sel_gpio_o    ( sel_gpio    ),
    .sel_timer_o   ( sel_timer   ),
    .we_o          ( bus_we      ),
    .addr_o        ( bus_addr    ),
    .be_o          ( bus_be      ),
    .wdata_o       ( bus_wdata   ),
    .rdata_bank0_i ( rdata_bank0 ),
    .rdata_bank1_i ( rdata_bank1 ),
    .rdata_ctrl_i  ( rdata_ctrl  ),
    .rdata_gpio_i  ( rdata_gpio  ),
    .rdata_timer_i ( rdata_timer )
  );

  // ----------------------------------------
  // Memories
  // ----------------------------------------
  sram_bank #(
    .NumWords ( `SOC_BANK_WORDS )
  ) i_bank0 (
    .clk_i,
    .req_i   ( sel_bank0   ),
    .we_i    ( bus_we      ),
    .addr_i  ( bus_addr    ),
    .be_i    ( bus_be      ),
    .wdata_i ( bus_wdata   ),
    .rdata_o ( rdata_bank0 )
  );

  sram_bank #(
    .NumWords ( `SOC_BANK_WORDS )
  ) i_bank1 (
    .clk_i,
    .req_i   ( sel_bank1   ),
    .we_i    ( bus_we      ),
    .addr_i  ( bus_addr    ),
    .be_i    ( bus_be      ),
    .wdata_i ( bus_wdata   ),
    .rdata_o ( rdata_bank1 )
  );

  // ----------------------------------------
  // Peripherals
  // ----------------------------------------
  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .req_i          ( sel_ctrl   ),
    .we_i           ( bus_we     ),
    .addr_i         ( bus_addr   ),
    .wdata_i        ( bus_wdata  ),
    .rdata_o        ( rdata_ctrl ),
    .fetch_en_i,
    .boot_addr_o,
    .fetch_enable_o
  );

  gpio_port i_gpio (
    .clk_i,
    .rst_n_i,
    .req_i          ( sel_gpio   ),
    .we_i           ( bus_we     ),
    .addr_i         ( bus_addr   ),
    .wdata_i        ( bus_wdata  ),
    .rdata_o        ( rdata_gpio ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq_o )
  );

  cmp_timer i_timer (
    .clk_i,
    .rst_n_i,
    .req_i   ( sel_timer   ),
    .we_i    ( bus_we      ),
    .addr_i  ( bus_addr    ),
    .wdata_i ( bus_wdata   ),
    .rdata_o ( rdata_timer ),
    .irq_o   ( timer_irq_o )
  );

endmodule

// File: verilog/cmp_timer.sv
`timescale 1ns/100ps

`include "soc_macros.svh"

module cmp_timer (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::word_t  wdata_i,
  output soc_pkg::word_t  rdata_o,
  output logic            irq_o
);

  localparam int unsigned OffW = $clog2(`SOC_PERIPH_SIZE);

  // ----------------------------------------
  // Register offsets
  // ----------------------------------------
  localparam logic [OffW-1:0] RegCount   = 'h0;
  localparam logic [OffW-1:0] RegCompare = 'h4;
  localparam logic [OffW-1:0] RegEnable  = 'h8;
  localparam logic [OffW-1:0] RegExpired = 'hC;

  logic [OffW-1:0] offset;
  logic            wr;
  soc_pkg::word_t  count_q;
  soc_pkg::word_t  compare_q;
  logic            enable_q;
  logic            expired_q;
  logic            hit;
  logic            expired_clr;
  soc_pkg::word_t  rdata_q;

  assign offset      = addr_i[OffW-1:0];
  assign wr          = req_i && we_i;
  assign hit         = enable_q && (count_q == compare_q);
  assign expired_clr = wr && (offset == RegExpired) && wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      // A bus write to the counter overrides the increment
      if (wr && offset == RegCount) begin
        count_q <= wdata_i;
      end else if (enable_q) begin
        count_q <= count_q + soc_pkg::word_t'(1);
      end
      if (wr && offset == RegCompare) begin
        compare_q <= wdata_i;
      end
      if (wr && offset == RegEnable) begin
        enable_q <= wdata_i[0];
      end
      // Sticky until software clears it
      expired_q <= hit | (expired_q & ~expired_clr);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offset)
        RegCount:   rdata_q <= count_q;
        RegCompare: rdata_q <= compare_q;
        RegEnable:  rdata_q <= soc_pkg::word_t'(enable_q);
        RegExpired: rdata_q <= soc_pkg::word_t'(expired_q);
        default:    rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o = rdata_q;
  assign irq_o   = expired_q;

  a_no_expiry_when_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(expired_q) |-> $past(enable_q));

endmodule

// File: verilog/gpio_port.sv
`timescale 1ns/100ps

`include "soc_macros.svh"

module gpio_port (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::word_t  wdata_i,
  output soc_pkg::word_t  rdata_o,
  input  soc_pkg::gpio_t  gpio_i,
  output soc_pkg::gpio_t  gpio_o,
  output soc_pkg::gpio_t  gpio_out_en_o,
  output soc_pkg::gpio_t  gpio_in_sync_o,
  output logic            irq_o
);

  localparam int unsigned OffW  = $clog2(`SOC_PERIPH_SIZE);
  localparam int unsigned GpioW = $bits(soc_pkg::gpio_t);

  // ----------------------------------------
  // Register offsets
  // ----------------------------------------
  localparam logic [OffW-1:0] RegDir    = 'h0;
  localparam logic [OffW-1:0] RegOut    = 'h4;
  localparam logic [OffW-1:0] RegIn     = 'h8;
  localparam logic [OffW-1:0] RegIrqEn  = 'hC;
  localparam logic [OffW-1:0] RegStatus = 'h10;

  logic [OffW-1:0] offset;
  soc_pkg::gpio_t  dir_q, out_q, irq_en_q, status_q;
  soc_pkg::gpio_t  sync1_q, sync2_q, prev_q;
  soc_pkg::gpio_t  rise, status_clr;
  soc_pkg::word_t  rdata_q;

  assign offset = addr_i[OffW-1:0];

  // Two-flop synchronizer, then one more stage for edge detection
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise       = sync2_q & ~prev_q;
  assign status_clr = (req_i && we_i && offset == RegStatus) ? wdata_i[GpioW-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
    end else begin
      if (req_i && we_i) begin
        case (offset)
          RegDir:   dir_q    <= wdata_i[GpioW-1:0];
          RegOut:   out_q    <= wdata_i[GpioW-1:0];
          RegIrqEn: irq_en_q <= wdata_i[GpioW-1:0];
          default: ;
        endcase
      end
      // New edges win over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | (rise & irq_en_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offset)
        RegDir:    rdata_q <= soc_pkg::word_t'(dir_q);
        RegOut:    rdata_q <= soc_pkg::word_t'(out_q);
        RegIn:     rdata_q <= soc_pkg::word_t'(sync2_q);
        RegIrqEn:  rdata_q <= soc_pkg::word_t'(irq_en_q);
        RegStatus: rdata_q <= soc_pkg::word_t'(status_q);
        default:   rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o        = rdata_q;
  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |status_q;

endmodule

// File: verilog/soc_ctrl_regs.sv
`timescale 1ns/100ps

`include "soc_macros.svh"

module soc_ctrl_regs (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::word_t  wdata_i,
  output soc_pkg::word_t  rdata_o,
  input  logic            fetch_en_i,
  output soc_pkg::addr_t  boot_addr_o,
  output logic            fetch_enable_o
);

  localparam int unsigned OffW = $clog2(`SOC_PERIPH_SIZE);

  // ----------------------------------------
  // Register offsets
  // ----------------------------------------
  localparam logic [OffW-1:0] RegBootAddr = 'h0;
  localparam logic [OffW-1:0] RegFetchEn  = 'h4;

  logic [OffW-1:0] offset;
  soc_pkg::addr_t  boot_addr_q;
  logic            fetch_en_q;
  soc_pkg::word_t  rdata_q;

  assign offset = addr_i[OffW-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= `SOC_BOOT_ADDR;
      fetch_en_q  <= 1'b0;
    end else if (req_i && we_i) begin
      case (offset)
        RegBootAddr: boot_addr_q <= wdata_i;
        RegFetchEn:  fetch_en_q  <= wdata_i[0];
        default: ;
      endcase
    end
  end

  // Read data, unknown offsets read as zero
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offset)
        RegBootAddr: rdata_q <= boot_addr_q;
        RegFetchEn:  rdata_q <= soc_pkg::word_t'(fetch_en_q);
        default:     rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o        = rdata_q;
  assign boot_addr_o    = boot_addr_q;
  // Pin or register starts the core
  assign fetch_enable_o = fetch_en_q | fetch_en_i;

endmodule

// File: verilog/sram_bank.sv
`timescale 1ns/100ps

module sram_bank #(
  parameter int unsigned NumWords = 256
) (
  input  logic            clk_i,
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::be_t    be_i,
  input  soc_pkg::word_t  wdata_i,
  output soc_pkg::word_t  rdata_o
);

  localparam int unsigned IdxW     = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam int unsigned NumBytes = $bits(soc_pkg::be_t);

  soc_pkg::word_t mem [NumWords];
  soc_pkg::word_t rdata_q;
  logic [IdxW-1:0] word_idx;

  // Bank windows are aligned to their size, so low bits give the index
  assign word_idx = addr_i[IdxW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < NumBytes; b++) begin
          if (be_i[b]) begin
            mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

  a_idx_in_range: assert property (@(posedge clk_i)
    req_i |-> (word_idx < NumWords));

endmodule

// File: verilog/bus_router.sv
`timescale 1ns/100ps

`include "soc_macros.svh"

module bus_router (
  input  logic            clk_i,
  input  logic            rst_n_i,

  // Manager side
  input  logic            req_i,
  input  logic            we_i,
  input  soc_pkg::addr_t  addr_i,
  input  soc_pkg::be_t    be_i,
  input  soc_pkg::word_t  wdata_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output soc_pkg::word_t  rdata_o,
  output logic            err_o,

  // Target side
  output logic            sel_bank0_o,
  output logic            sel_bank1_o,
  output logic            sel_ctrl_o,
  output logic            sel_gpio_o,
  output logic            sel_timer_o,
  output logic            we_o,
  output soc_pkg::addr_t  addr_o,
  output soc_pkg::be_t    be_o,
  output soc_pkg::word_t  wdata_o,
  input  soc_pkg::word_t  rdata_bank0_i,
  input  soc_pkg::word_t  rdata_bank1_i,
  input  soc_pkg::word_t  rdata_ctrl_i,
  input  soc_pkg::word_t  rdata_gpio_i,
  input  soc_pkg::word_t  rdata_timer_i
);

  localparam soc_pkg::addr_t BankSize = `SOC_BANK_WORDS * 4;

  soc_pkg::tgt_sel_e tgt_sel;
  soc_pkg::tgt_sel_e rsp_sel_q;
  logic              rsp_valid_q;

  // Unsigned distance from base, so addresses below base fall out too
  function automatic logic in_window(soc_pkg::addr_t addr, soc_pkg::addr_t base,
                                     soc_pkg::addr_t size);
    soc_pkg::addr_t offset;
    offset = addr - base;
    return offset < size;
  endfunction

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  always_comb begin
    tgt_sel = soc_pkg::TGT_ERROR;
    if (in_window(addr_i, `SOC_BANK0_BASE, BankSize)) begin
      tgt_sel = soc_pkg::TGT_BANK0;
    end else if (in_window(addr_i, `SOC_BANK1_BASE, BankSize)) begin
      tgt_sel = soc_pkg::TGT_BANK1;
    end else if (in_window(addr_i, `SOC_CTRL_BASE, `SOC_PERIPH_SIZE)) begin
      tgt_sel = soc_pkg::TGT_CTRL;
    end else if (in_window(addr_i, `SOC_GPIO_BASE, `SOC_PERIPH_SIZE)) begin
      tgt_sel = soc_pkg::TGT_GPIO;
    end else if (in_window(addr_i, `SOC_TIMER_BASE, `SOC_PERIPH_SIZE)) begin
      tgt_sel = soc_pkg::TGT_TIMER;
    end
  end

  // All targets accept at once
  assign gnt_o = req_i;

  assign sel_bank0_o = req_i && (tgt_sel == soc_pkg::TGT_BANK0);
  assign sel_bank1_o = req_i && (tgt_sel == soc_pkg::TGT_BANK1);
  assign sel_ctrl_o  = req_i && (tgt_sel == soc_pkg::TGT_CTRL);
  assign sel_gpio_o  = req_i && (tgt_sel == soc_pkg::TGT_GPIO);
  assign sel_timer_o = req_i && (tgt_sel == soc_pkg::TGT_TIMER);

  assign we_o    = we_i;
  assign addr_o  = addr_i;
  assign be_o    = be_i;
  assign wdata_o = wdata_i;

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_sel_q   <= soc_pkg::TGT_ERROR;
    end else begin
      rsp_valid_q <= req_i;
      rsp_sel_q   <= tgt_sel;
    end
  end

  always_comb begin
    case (rsp_sel_q)
      soc_pkg::TGT_BANK0: rdata_o = rdata_bank0_i;
      soc_pkg::TGT_BANK1: rdata_o = rdata_bank1_i;
      soc_pkg::TGT_CTRL:  rdata_o = rdata_ctrl_i;
      soc_pkg::TGT_GPIO:  rdata_o = rdata_gpio_i;
      soc_pkg::TGT_TIMER: rdata_o = rdata_timer_i;
      default:            rdata_o = `SOC_ERR_RDATA;
    endcase
  end

  assign rvalid_o = rsp_valid_q;
  // Error responder for unmapped space
  assign err_o    = rsp_valid_q && (rsp_sel_q == soc_pkg::TGT_ERROR);

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({sel_bank0_o, sel_bank1_o, sel_ctrl_o, sel_gpio_o, sel_timer_o}));

  a_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o |-> $past(req_i));

endmodule

// File: verilog/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

  // ----------------------------------------
  // Bus payload types
  // ----------------------------------------
  typedef logic [`SOC_DATA_W-1:0]   word_t;
  typedef logic [`SOC_ADDR_W-1:0]   addr_t;
  typedef logic [`SOC_DATA_W/8-1:0] be_t;

  // One bit per pin
  typedef logic [`SOC_GPIO_COUNT-1:0] gpio_t;

  // ----------------------------------------
  // Router targets
  // ----------------------------------------
  typedef enum logic [2:0] {
    TGT_BANK0 = 3'd0,
    TGT_BANK1 = 3'd1,
    TGT_CTRL  = 3'd2,
    TGT_GPIO  = 3'd3,
    TGT_TIMER = 3'd4,
    TGT_ERROR = 3'd5
  } tgt_sel_e;

endpackage

// File: verilog/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ----------------------------------------
// Bus widths and sizes
// ----------------------------------------
`define SOC_DATA_W      32
`define SOC_ADDR_W      32
`define SOC_GPIO_COUNT  16
`define SOC_BANK_WORDS  256

// ----------------------------------------
// Address map
// ----------------------------------------
`define SOC_BANK0_BASE  32'h1000_0000
`define SOC_BANK1_BASE  32'h1000_0400
`define SOC_CTRL_BASE   32'h0300_0000
`define SOC_GPIO_BASE   32'h0300_1000
`define SOC_TIMER_BASE  32'h0300_2000
`define SOC_PERIPH_SIZE 32'h0000_1000

// Reset values and fixed responses
`define SOC_ERR_RDATA   32'hBADC_AB1E
`define SOC_BOOT_ADDR   32'h1000_0000

`endif
